//--- src/warp_pkg.sv
package warp_pkg;

    // datapath and register file geometry
    localparam int XLEN     = 64;
    localparam int WORD_W   = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    // arithmetic unit operation select
    localparam logic [1:0] XARITH_OP_ADD = 2'd0;
    localparam logic [1:0] XARITH_OP_SLT = 2'd1;
    localparam logic [1:0] XARITH_OP_CMP = 2'd2;

    // logic unit operation select
    localparam logic [2:0] XLOGIC_OP_AND = 3'd0;
    localparam logic [2:0] XLOGIC_OP_OR  = 3'd1;
    localparam logic [2:0] XLOGIC_OP_XOR = 3'd2;
    localparam logic [2:0] XLOGIC_OP_SLA = 3'd4;

    // unit select carried with every issued operation
    localparam logic UNIT_ARITH = 1'b0;
    localparam logic UNIT_LOGIC = 1'b1;

    typedef struct packed {
        logic [1:0] opsel;
        logic       sub;
        logic       is_unsigned;
        // set for min, clear for max
        logic       cmp_min;
        // branch on equality instead of less-than
        logic       branch_equal;
        logic       branch_invert;
        logic       word;
    } xarith_ctl_s;

    typedef struct packed {
        logic [2:0] opsel;
        logic       invert;
        logic [1:0] sll;
        // must be zero
        logic [1:0] reserved;
    } xlogic_ctl_s;

    // one control word, decoded per unit select
    // the logic view is called lgc since logic is a keyword
    typedef union packed {
        xarith_ctl_s arith;
        xlogic_ctl_s lgc;
    } xctl_u;

endpackage

//--- src/warp_xrf.sv
`timescale 1ns/1ps

module warp_xrf (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    // read addresses, sampled on the rising edge
    input  logic [warp_pkg::REG_AW-1:0] i_rs1_addr,
    input  logic [warp_pkg::REG_AW-1:0] i_rs2_addr,
    // single write port
    input  logic                         i_wen,
    input  logic [warp_pkg::REG_AW-1:0] i_rd_addr,
    input  logic [warp_pkg::XLEN-1:0]   i_rd_wdata,
    // read data, valid one cycle after the address
    output logic [warp_pkg::XLEN-1:0]   o_rs1_rdata,
    output logic [warp_pkg::XLEN-1:0]   o_rs2_rdata
);
    logic [warp_pkg::XLEN-1:0] regs [warp_pkg::NUM_REGS];
    logic [warp_pkg::XLEN-1:0] rs1_q;
    logic [warp_pkg::XLEN-1:0] rs2_q;
    logic                      wr_en;

    // x0 is never written, so it keeps its reset value of zero
    assign wr_en = i_wen && (i_rd_addr != '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < warp_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            rs1_q <= '0;
            rs2_q <= '0;
        end else begin
            if (wr_en) begin
                regs[i_rd_addr] <= i_rd_wdata;
            end
            // bypass: a read of the register being written sees the new data
            if (wr_en && (i_rs1_addr == i_rd_addr)) begin
                rs1_q <= i_rd_wdata;
            end else begin
                rs1_q <= regs[i_rs1_addr];
            end
            if (wr_en && (i_rs2_addr == i_rd_addr)) begin
                rs2_q <= i_rd_wdata;
            end else begin
                rs2_q <= regs[i_rs2_addr];
            end
        end
    end

    assign o_rs1_rdata = rs1_q;
    assign o_rs2_rdata = rs2_q;
endmodule

//--- src/warp_xread.sv
`timescale 1ns/1ps

module warp_xread (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    // issue fields
    input  logic                         i_valid,
    input  logic [warp_pkg::REG_AW-1:0] i_rs1,
    input  logic [warp_pkg::REG_AW-1:0] i_rs2,
    input  logic [warp_pkg::REG_AW-1:0] i_rd,
    input  logic                         i_use_imm,
    input  logic [warp_pkg::XLEN-1:0]   i_imm,
    input  logic                         i_unit,
    input  warp_pkg::xctl_u              i_ctl,
    // write-back from the execute stage
    input  logic                         i_wen,
    input  logic [warp_pkg::REG_AW-1:0] i_wb_rd,
    input  logic [warp_pkg::XLEN-1:0]   i_wb_data,
    // operands and fields, one cycle after issue
    output logic                         o_valid,
    output logic [warp_pkg::XLEN-1:0]   o_op1,
    output logic [warp_pkg::XLEN-1:0]   o_op2,
    output logic [warp_pkg::REG_AW-1:0] o_rd,
    output logic                         o_unit,
    output warp_pkg::xctl_u              o_ctl
);
    logic [warp_pkg::XLEN-1:0]   rs2_rdata;
    logic [warp_pkg::XLEN-1:0]   imm_q;
    logic                        use_imm_q;

    // file reads line up with the registered fields below
    warp_xrf u_xrf (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rs1_addr  (i_rs1),
        .i_rs2_addr  (i_rs2),
        .i_wen       (i_wen),
        .i_rd_addr   (i_wb_rd),
        .i_rd_wdata  (i_wb_data),
        .o_rs1_rdata (o_op1),
        .o_rs2_rdata (rs2_rdata)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid   <= 1'b0;
            o_rd      <= '0;
            o_unit    <= warp_pkg::UNIT_ARITH;
            o_ctl     <= '0;
            use_imm_q <= 1'b0;
        end else begin
            o_valid   <= i_valid;
            o_rd      <= i_rd;
            o_unit    <= i_unit;
            o_ctl     <= i_ctl;
            use_imm_q <= i_use_imm;
        end
    end

    // immediate payload
    always_ff @(posedge i_clk) begin
        imm_q <= i_imm;
    end

    // immediate replaces rs2 when selected
    assign o_op2 = use_imm_q ? imm_q : rs2_rdata;
endmodule

//--- src/warp_xarith.sv
`timescale 1ns/1ps

module warp_xarith (
    input  logic [warp_pkg::XLEN-1:0] i_op1,
    input  logic [warp_pkg::XLEN-1:0] i_op2,
    input  warp_pkg::xarith_ctl_s     i_ctl,
    output logic [warp_pkg::XLEN-1:0] o_result,
    output logic                      o_branch
);
    localparam int XL = warp_pkg::XLEN;
    localparam int WW = warp_pkg::WORD_W;

    logic [XL-1:0] sum;
    logic [XL-1:0] add_result;
    logic [XL:0]   cmp_a;
    logic [XL:0]   cmp_b;
    logic [XL:0]   diff;
    logic          lt;
    logic          eq;
    logic          take_op2;

    // add or subtract, carry-in completes the two's complement
    assign sum = i_op1 + (i_op2 ^ {XL{i_ctl.sub}}) + {{(XL-1){1'b0}}, i_ctl.sub};

    // word mode keeps the low half and sign-extends it
    assign add_result = i_ctl.word ? {{(XL-WW){sum[WW-1]}}, sum[WW-1:0]} : sum;

    // comparison subtract at 65 bits
    // extension bit is the sign for signed, zero for unsigned
    assign cmp_a = {i_ctl.is_unsigned ? 1'b0 : i_op1[XL-1], i_op1};
    assign cmp_b = {i_ctl.is_unsigned ? 1'b0 : i_op2[XL-1], i_op2};
    assign diff  = cmp_a - cmp_b;

    // top bit is sign and borrow at once, no overflow at this width
    assign lt = diff[XL];
    assign eq = (i_op1 == i_op2);

    // min picks op2 when op2 is smaller, max when op2 is larger
    assign take_op2 = lt ^ i_ctl.cmp_min;

    always_comb begin
        case (i_ctl.opsel)
            warp_pkg::XARITH_OP_ADD: o_result = add_result;
            warp_pkg::XARITH_OP_SLT: o_result = {{(XL-1){1'b0}}, lt};
            warp_pkg::XARITH_OP_CMP: o_result = take_op2 ? i_op2 : i_op1;
            default:                 o_result = '0;
        endcase
    end

    // eq/ne or lt/ge, ltu/geu through is_unsigned
    assign o_branch = (i_ctl.branch_equal ? eq : lt) ^ i_ctl.branch_invert;
endmodule

//--- src/warp_xlogic.sv
`timescale 1ns/1ps

module warp_xlogic (
    input  logic [warp_pkg::XLEN-1:0] i_op1,
    input  logic [warp_pkg::XLEN-1:0] i_op2,
    input  warp_pkg::xlogic_ctl_s     i_ctl,
    output logic [warp_pkg::XLEN-1:0] o_result
);
    localparam int XL = warp_pkg::XLEN;

    logic [XL-1:0] op2_inv;
    logic [XL-1:0] shl1;
    logic [XL-1:0] shl;
    logic [XL-1:0] sla_result;

    // andn, orn and xnor come from inverting op2
    assign op2_inv = i_op2 ^ {XL{i_ctl.invert}};

    // shift op1 by 0..3 in two steps
    assign shl1 = i_ctl.sll[1] ? {i_op1[XL-3:0], 2'b00} : i_op1;
    assign shl  = i_ctl.sll[0] ? {shl1[XL-2:0], 1'b0} : shl1;

    // base scaled by 2/4/8 plus offset for address generation
    // offset is never inverted
    assign sla_result = shl + i_op2;

    always_comb begin
        case (i_ctl.opsel)
            warp_pkg::XLOGIC_OP_AND: o_result = i_op1 & op2_inv;
            warp_pkg::XLOGIC_OP_OR:  o_result = i_op1 | op2_inv;
            warp_pkg::XLOGIC_OP_XOR: o_result = i_op1 ^ op2_inv;
            warp_pkg::XLOGIC_OP_SLA: o_result = sla_result;
            // unassigned encodings
            default:                 o_result = '0;
        endcase
    end
endmodule

//--- src/warp_xexec.sv
`timescale 1ns/1ps

module warp_xexec (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_valid,
    input  logic [warp_pkg::XLEN-1:0]   i_op1,
    input  logic [warp_pkg::XLEN-1:0]   i_op2,
    input  logic [warp_pkg::REG_AW-1:0] i_rd,
    input  logic                         i_unit,
    input  warp_pkg::xctl_u              i_ctl,
    // registered result, one cycle after the inputs
    output logic                         o_valid,
    output logic [warp_pkg::XLEN-1:0]   o_result,
    output logic                         o_branch,
    output logic [warp_pkg::REG_AW-1:0] o_rd
);
    logic [warp_pkg::XLEN-1:0] arith_result;
    logic [warp_pkg::XLEN-1:0] logic_result;
    logic [warp_pkg::XLEN-1:0] result;
    logic                      arith_branch;
    logic                      branch;

    // both units see the same word, each through its own view
    warp_xarith u_xarith (
        .i_op1    (i_op1),
        .i_op2    (i_op2),
        .i_ctl    (i_ctl.arith),
        .o_result (arith_result),
        .o_branch (arith_branch)
    );

    warp_xlogic u_xlogic (
        .i_op1    (i_op1),
        .i_op2    (i_op2),
        .i_ctl    (i_ctl.lgc),
        .o_result (logic_result)
    );

    assign result = (i_unit == warp_pkg::UNIT_LOGIC) ? logic_result : arith_result;

    // branch only means something for the arithmetic unit
    assign branch = (i_unit == warp_pkg::UNIT_ARITH) && arith_branch;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid  <= 1'b0;
            o_result <= '0;
            o_branch <= 1'b0;
            o_rd     <= '0;
        end else begin
            o_valid  <= i_valid;
            o_result <= result;
            o_branch <= branch;
            o_rd     <= i_rd;
        end
    end
endmodule

//--- src/warp_xcore.sv
`timescale 1ns/1ps

module warp_xcore (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    // issue, one operation per cycle at most
    input  logic                         i_valid,
    input  logic [warp_pkg::REG_AW-1:0] i_rs1,
    input  logic [warp_pkg::REG_AW-1:0] i_rs2,
    input  logic [warp_pkg::REG_AW-1:0] i_rd,
    input  logic                         i_use_imm,
    input  logic [warp_pkg::XLEN-1:0]   i_imm,
    input  logic                         i_unit,
    input  warp_pkg::xctl_u              i_ctl,
    // result, two cycles after issue
    output logic                         o_valid,
    output logic [warp_pkg::XLEN-1:0]   o_result,
    output logic                         o_branch,
    output logic [warp_pkg::REG_AW-1:0] o_rd
);
    // read stage to execute stage
    logic                         rd_valid;
    logic [warp_pkg::XLEN-1:0]   rd_op1;
    logic [warp_pkg::XLEN-1:0]   rd_op2;
    logic [warp_pkg::REG_AW-1:0] rd_rd;
    logic                         rd_unit;
    warp_pkg::xctl_u              rd_ctl;

    // execute outputs double as the write-back port
    warp_xread u_xread (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_valid),
        .i_rs1     (i_rs1),
        .i_rs2     (i_rs2),
        .i_rd      (i_rd),
        .i_use_imm (i_use_imm),
        .i_imm     (i_imm),
        .i_unit    (i_unit),
        .i_ctl     (i_ctl),
        .i_wen     (o_valid),
        .i_wb_rd   (o_rd),
        .i_wb_data (o_result),
        .o_valid   (rd_valid),
        .o_op1     (rd_op1),
        .o_op2     (rd_op2),
        .o_rd      (rd_rd),
        .o_unit    (rd_unit),
        .o_ctl     (rd_ctl)
    );

    warp_xexec u_xexec (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (rd_valid),
        .i_op1    (rd_op1),
        .i_op2    (rd_op2),
        .i_rd     (rd_rd),
        .i_unit   (rd_unit),
        .i_ctl    (rd_ctl),
        .o_valid  (o_valid),
        .o_result (o_result),
        .o_branch (o_branch),
        .o_rd     (o_rd)
    );
endmodule

//--- verif/warp_xcore_assert.sv
`timescale 1ns/1ps

module warp_xcore_assert (
    input logic                         i_clk,
    input logic                         i_rst_n,
    input logic                         i_valid,
    input logic [warp_pkg::REG_AW-1:0] i_rs1,
    input logic [warp_pkg::REG_AW-1:0] i_rs2,
    input logic [warp_pkg::REG_AW-1:0] i_rd,
    input logic                         i_use_imm,
    input logic [warp_pkg::XLEN-1:0]   i_imm,
    input logic                         i_unit,
    input warp_pkg::xctl_u              i_ctl,
    input logic                         o_valid,
    input logic [warp_pkg::XLEN-1:0]   o_result,
    input logic                         o_branch,
    input logic [warp_pkg::REG_AW-1:0] o_rd
);
    localparam int XL = warp_pkg::XLEN;
    localparam int WW = warp_pkg::WORD_W;
    localparam int AW = warp_pkg::REG_AW;

    // shadow register file written only with predicted results
    logic [XL-1:0] shadow [warp_pkg::NUM_REGS];
    // prediction pipeline whose stage 2 lines up with o_valid
    logic          p1_valid;
    logic          p2_valid;
    logic [AW-1:0] p1_rd;
    logic [AW-1:0] p2_rd;
    logic [XL-1:0] p1_res;
    logic [XL-1:0] p2_res;
    logic          p1_br;
    logic          p2_br;
    logic [XL-1:0] op1;
    logic [XL-1:0] op2;
    int            fail_count = 0;

    // x0 reads zero and a result on o_valid this cycle is already visible
    function automatic logic [XL-1:0] read_reg(input logic [AW-1:0] a);
        if (a == '0) return '0;
        if (p2_valid && p2_rd == a) return p2_res;
        return shadow[a];
    endfunction

    function automatic logic less_than(input logic [XL-1:0] a, input logic [XL-1:0] b,
                                       input logic uns);
        return uns ? (a < b) : ($signed(a) < $signed(b));
    endfunction

    function automatic logic [XL-1:0] predict_result(input logic [XL-1:0] a,
                                                     input logic [XL-1:0] b, input logic unit,
                                                     input warp_pkg::xctl_u ctl);
        logic [XL-1:0] s;
        logic [XL-1:0] m;
        s = ctl.arith.sub ? a - b : a + b;
        m = ctl.lgc.invert ? ~b : b;
        if (unit == warp_pkg::UNIT_LOGIC) begin
            case (ctl.lgc.opsel)
                warp_pkg::XLOGIC_OP_AND: return a & m;
                warp_pkg::XLOGIC_OP_OR:  return a | m;
                warp_pkg::XLOGIC_OP_XOR: return a ^ m;
                // offset added as is
                warp_pkg::XLOGIC_OP_SLA: return (a << ctl.lgc.sll) + b;
                default:                 return '0;
            endcase
        end
        case (ctl.arith.opsel)
            warp_pkg::XARITH_OP_ADD: return ctl.arith.word ? XL'($signed(s[WW-1:0])) : s;
            warp_pkg::XARITH_OP_SLT: return XL'(less_than(a, b, ctl.arith.is_unsigned));
            warp_pkg::XARITH_OP_CMP:
                return (less_than(a, b, ctl.arith.is_unsigned) ^ ctl.arith.cmp_min) ? b : a;
            default:                 return '0;
        endcase
    endfunction

    function automatic logic predict_branch(input logic [XL-1:0] a, input logic [XL-1:0] b,
                                            input logic unit, input warp_pkg::xctl_u ctl);
        if (unit == warp_pkg::UNIT_LOGIC) return 1'b0;
        return (ctl.arith.branch_equal ? (a == b) : less_than(a, b, ctl.arith.is_unsigned))
               ^ ctl.arith.branch_invert;
    endfunction

    always_comb begin
        op1 = read_reg(i_rs1);
        op2 = i_use_imm ? i_imm : read_reg(i_rs2);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < warp_pkg::NUM_REGS; i++) begin
                shadow[i] <= '0;
            end
            p1_valid <= 1'b0;
            p2_valid <= 1'b0;
            p1_rd    <= '0;
            p2_rd    <= '0;
            p1_res   <= '0;
            p2_res   <= '0;
            p1_br    <= 1'b0;
            p2_br    <= 1'b0;
        end else begin
            p1_valid <= i_valid;
            p1_rd    <= i_rd;
            p1_res   <= predict_result(op1, op2, i_unit, i_ctl);
            p1_br    <= predict_branch(op1, op2, i_unit, i_ctl);
            p2_valid <= p1_valid;
            p2_rd    <= p1_rd;
            p2_res   <= p1_res;
            p2_br    <= p1_br;
            // write-back at the edge that ends the result cycle
            if (p2_valid && p2_rd != '0) begin
                shadow[p2_rd] <= p2_res;
            end
        end
    end

    a_reset: assert property (@(posedge i_clk)
        !i_rst_n |-> !o_valid && !o_branch && o_result == '0 && o_rd == '0)
        else begin
            fail_count++;
            $error("[ERROR] %0t result outputs not cleared while reset is held", $time);
        end

    // exactly two cycles from issue to result
    a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_valid == p2_valid)
        else begin
            fail_count++;
            $error("[ERROR] %0t o_valid got %b exp %b", $time, $sampled(o_valid),
                   $sampled(p2_valid));
        end

    a_rd: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_valid |-> o_rd == p2_rd)
        else begin
            fail_count++;
            $error("[ERROR] %0t o_rd got %0d exp %0d", $time, $sampled(o_rd), $sampled(p2_rd));
        end

    a_result: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> o_result == p2_res)
        else begin
            fail_count++;
            $error("[ERROR] %0t o_result got %h exp %h", $time, $sampled(o_result),
                   $sampled(p2_res));
        end

    a_branch: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> o_branch == p2_br)
        else begin
            fail_count++;
            $error("[ERROR] %0t o_branch got %b exp %b", $time, $sampled(o_branch),
                   $sampled(p2_br));
        end
endmodule

bind warp_xcore warp_xcore_assert u_chk (.*);

//--- verif/warp_xcore_tb.sv
`timescale 1ns/1ps

module warp_xcore_tb;
    localparam int XL = warp_pkg::XLEN;
    localparam int AW = warp_pkg::REG_AW;
    // longest single wait in cycles
    localparam int WAIT_LIMIT = 20;
    localparam logic [1:0] ADD = warp_pkg::XARITH_OP_ADD;
    localparam logic [1:0] SLT = warp_pkg::XARITH_OP_SLT;
    localparam logic [1:0] CMP = warp_pkg::XARITH_OP_CMP;
    localparam logic ARITH = warp_pkg::UNIT_ARITH;
    localparam logic LOGIC = warp_pkg::UNIT_LOGIC;

    logic            i_clk;
    logic            i_rst_n;
    logic            i_valid;
    logic [AW-1:0]   i_rs1;
    logic [AW-1:0]   i_rs2;
    logic [AW-1:0]   i_rd;
    logic            i_use_imm;
    logic [XL-1:0]   i_imm;
    logic            i_unit;
    warp_pkg::xctl_u i_ctl;
    logic            o_valid;
    logic [XL-1:0]   o_result;
    logic            o_branch;
    logic [AW-1:0]   o_rd;
    integer          seed;
    int              timeout_count;

    warp_xcore UUT (.*);

    always #4 i_clk = ~i_clk;

    function automatic warp_pkg::xctl_u arith_ctl(input logic [1:0] opsel, input logic sub,
                                                  input logic uns, input logic cmp_min,
                                                  input logic beq, input logic binv,
                                                  input logic word);
        warp_pkg::xctl_u c;
        c.arith = {opsel, sub, uns, cmp_min, beq, binv, word};
        return c;
    endfunction

    function automatic warp_pkg::xctl_u logic_ctl(input logic [2:0] opsel, input logic inv,
                                                  input logic [1:0] sll);
        warp_pkg::xctl_u c;
        // reserved bits stay zero
        c.lgc = {opsel, inv, sll, 2'b00};
        return c;
    endfunction

    // one issue strobe sampled at the following edge
    task automatic issue(input logic [AW-1:0] rs1, input logic [AW-1:0] rs2,
                         input logic [AW-1:0] rd, input logic use_imm, input logic [XL-1:0] imm,
                         input logic unit, input warp_pkg::xctl_u ctl);
        @(posedge i_clk);
        i_valid   <= 1'b1;
        i_rs1     <= rs1;
        i_rs2     <= rs2;
        i_rd      <= rd;
        i_use_imm <= use_imm;
        i_imm     <= imm;
        i_unit    <= unit;
        i_ctl     <= ctl;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge i_clk);
            i_valid <= 1'b0;
        end
    endtask

    // x0 | imm puts a known value into rd
    task automatic load_reg(input logic [AW-1:0] rd, input logic [XL-1:0] value);
        issue('0, '0, rd, 1'b1, value, LOGIC, logic_ctl(warp_pkg::XLOGIC_OP_OR, 1'b0, 2'd0));
    endtask

    // back-to-back ops read x1..x11 and write x16..x21 so none depends on another
    task automatic random_ops(input logic unit, input warp_pkg::xctl_u ctl);
        logic [AW-1:0] rs1;
        logic [AW-1:0] rs2;
        logic [XL-1:0] imm;
        for (int k = 0; k < 6; k++) begin
            rs1 = AW'(1 + {$random(seed)} % 11);
            // one pair of equal operands for the eq/ne branches
            rs2 = (k == 3) ? rs1 : AW'(1 + {$random(seed)} % 11);
            imm = {$random(seed), $random(seed)};
            issue(rs1, rs2, AW'(16 + k), k == 5, imm, unit, ctl);
        end
    endtask

    // outputs sampled on the falling edge away from the driving edge
    task automatic wait_level(input logic level);
        int n;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge i_clk);
            if (o_valid == level) break;
        end
        if (n == WAIT_LIMIT) begin
            $display("timeout: o_valid never went to %b within %0d cycles", level, WAIT_LIMIT);
            timeout_count++;
        end
    endtask

    initial begin
        seed          = 32'h2472_55ad;
        timeout_count = 0;
        i_clk         = 1'b0;
        i_rst_n       = 1'b0;
        i_valid       = 1'b0;
        i_rs1         = '0;
        i_rs2         = '0;
        i_rd          = '0;
        i_use_imm     = 1'b0;
        i_imm         = '0;
        i_unit        = ARITH;
        i_ctl         = '0;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // first read after reset sees an empty file
        issue(5'd7, 5'd0, 5'd1, 1'b0, '0, LOGIC, logic_ctl(warp_pkg::XLOGIC_OP_OR, 1'b0, 2'd0));
        idle(1);
        wait_level(1'b1);

        // random operands plus word overflow and sign corners
        for (int r = 1; r <= 8; r++) begin
            load_reg(AW'(r), {$random(seed), $random(seed)});
        end
        load_reg(5'd9, 64'h0000_0000_7fff_ffff);
        load_reg(5'd10, '1);
        load_reg(5'd11, 64'h8000_0000_0000_0000);
        idle(2);

        // add/sub, word mode, slt/sltu, min/max signed and unsigned
        random_ops(ARITH, arith_ctl(ADD, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(ADD, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(ADD, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
        random_ops(ARITH, arith_ctl(ADD, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
        random_ops(ARITH, arith_ctl(SLT, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(SLT, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(CMP, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(CMP, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(CMP, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(CMP, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        // branches eq, ne, lt, ge, ltu, geu
        random_ops(ARITH, arith_ctl(SLT, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(SLT, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0));
        random_ops(ARITH, arith_ctl(SLT, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(SLT, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
        random_ops(ARITH, arith_ctl(SLT, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        random_ops(ARITH, arith_ctl(SLT, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
        // and/or/xor with and without inversion then shift-add for every sll
        for (int inv = 0; inv < 2; inv++) begin
            random_ops(LOGIC, logic_ctl(warp_pkg::XLOGIC_OP_AND, inv[0], 2'd0));
            random_ops(LOGIC, logic_ctl(warp_pkg::XLOGIC_OP_OR, inv[0], 2'd0));
            random_ops(LOGIC, logic_ctl(warp_pkg::XLOGIC_OP_XOR, inv[0], 2'd0));
        end
        for (int s = 0; s < 4; s++) begin
            random_ops(LOGIC, logic_ctl(warp_pkg::XLOGIC_OP_SLA, 1'b0, s[1:0]));
        end
        idle(2);

        // consumer two cycles after its producer reads through the bypass
        load_reg(5'd12, {$random(seed), $random(seed)});
        load_reg(5'd22, 64'd5);
        issue(5'd12, 5'd11, 5'd23, 1'b0, '0, ARITH, arith_ctl(ADD, 1'b0, 1'b0, 1'b0, 1'b0,
                                                             1'b0, 1'b0));
        // x0 write is dropped even when read in the bypass slot
        load_reg(5'd0, 64'hdead_beef_0bad_f00d);
        load_reg(5'd24, 64'd1);
        issue(5'd0, 5'd12, 5'd25, 1'b0, '0, LOGIC, logic_ctl(warp_pkg::XLOGIC_OP_XOR, 1'b0,
                                                             2'd0));
        // x0 still reads zero once the dropped write is past
        issue(5'd0, 5'd0, 5'd26, 1'b0, '0, LOGIC, logic_ctl(warp_pkg::XLOGIC_OP_OR, 1'b0,
                                                            2'd0));
        idle(3);
        wait_level(1'b0);

        $display("assertion failures: %0d, timeouts: %0d", UUT.u_chk.fail_count, timeout_count);
        if (UUT.u_chk.fail_count == 0 && timeout_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end
endmodule

//--- vlog.f
src/warp_pkg.sv
src/warp_xrf.sv
src/warp_xread.sv
src/warp_xarith.sv
src/warp_xlogic.sv
src/warp_xexec.sv
src/warp_xcore.sv
verif/warp_xcore_assert.sv
verif/warp_xcore_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module warp_xcore_tb -o warp_xcore_sim || exit 1
./obj_dir/warp_xcore_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && echo "simulation failed" && exit 1
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
